// File: filelist.f
+incdir+include
verilog/video_pkg.sv
verilog/mem_pkg.sv
verilog/wr_port_if.sv
verilog/pixel_capture.sv
verilog/display_scan.sv
verilog/mem_arbiter.sv
verilog/frame_store_top.sv
tests/frame_store_tb.sv

// File: Bender.yml
package:
  name: frame_store

sources:
  - include_dirs:
      - include
    files:
      - verilog/video_pkg.sv
      - verilog/mem_pkg.sv
      - verilog/wr_port_if.sv
      - verilog/pixel_capture.sv
      - verilog/display_scan.sv
      - verilog/mem_arbiter.sv
      - verilog/frame_store_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/frame_store_tb.sv

// File: tests/frame_store_tb.sv
// frame store testbench
// random pixel frames in, memory model on the port, raster and contents checked

`default_nettype none

`include "frame_macros.svh"

module frame_store_tb;

   localparam int FRAME_PIX      = `H_ACTIVE * `V_ACTIVE;
   localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
   localparam int RESET_CYCLES   = 16;
   localparam int LAT            = `MEM_READ_LATENCY;
   // one word and two stray lanes ahead of the second frame for sof to restart
   localparam int LEAD_PIX       = `PIX_PER_WORD + 2;
   // valid is high half the time, plus up to two stall cycles per word
   localparam int CAPTURE_CYCLES = 2 * FRAME_PIX + 2 * `FRAME_WORDS;
   localparam int LEAD_CYCLES    = 2 * LEAD_PIX + 2;
   // two captured frames and the lead-in, quiet frame with its wait, one frame of margin
   localparam int CYCLE_LIMIT    = RESET_CYCLES + 2 * CAPTURE_CYCLES + LEAD_CYCLES
                                   + 3 * FRAME_CYCLES;

   logic               clk;
   logic               arst_n;
   logic               pix_valid;
   logic               pix_ready;
   video_pkg::pixel_t  pix_data;
   logic               pix_sof;
   video_pkg::pixel_t  video_pixel;
   logic               video_blank;
   logic               video_hsync;
   logic               video_vsync;
   mem_pkg::mem_addr_t mem_addr;
   logic               mem_rd;
   logic               mem_we;
   mem_pkg::mem_word_t mem_wdata;
   mem_pkg::mem_word_t mem_rdata;

   // stimulus and reference model state
   logic [31:0]        lfsr_state = 32'hdd598fae;
   logic [`WORD_W-1:0] acc_word = '0;
   int                 lane_cnt = 0;
   int                 pix_idx = 0;
   int                 word_idx = 0;
   logic [7:0]         ref_pix [0:FRAME_PIX-1];
   logic [`WORD_W-1:0] word_q [$];
   int                 addr_q [$];
   int                 pending_words = 0;

   // memory model and monitor state
   logic [`WORD_W-1:0] mem [0:`FRAME_WORDS-1];
   logic [`WORD_W-1:0] rd_pipe [0:LAT-1];
   logic [LAT:0]       rd_hist = '0;
   int                 cycle_cnt = 0;
   int                 stall_run = 0;
   int                 last_hsync = -1;
   int                 last_vsync = -1;
   int                 col_cnt = 0;
   int                 row_cnt = 0;
   int                 pixels_checked = 0;
   int                 quiet_state = 0;
   logic               prev_hsync = 1'b0;
   logic               prev_vsync = 1'b0;
   logic               prev_blank = 1'b1;

   frame_store_top dut0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .pix_valid   (pix_valid),
      .pix_ready   (pix_ready),
      .pix_data    (pix_data),
      .pix_sof     (pix_sof),
      .video_pixel (video_pixel),
      .video_blank (video_blank),
      .video_hsync (video_hsync),
      .video_vsync (video_vsync),
      .mem_addr    (mem_addr),
      .mem_rd      (mem_rd),
      .mem_we      (mem_we),
      .mem_wdata   (mem_wdata),
      .mem_rdata   (mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////
   // helpers
   ////////////////////

   // taps 32, 22, 2, 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   task automatic draw_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int b = 0; b < n; b++) begin
         lfsr_state = next_lfsr(lfsr_state);
         val = {val[6:0], lfsr_state[0]};
      end
   endtask

   task automatic stop_run();
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic fail_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      stop_run();
   endtask

   task automatic fail_text(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   // threshold, then pack four pixels with lane0 in the top bits
   task automatic record_pixel(input logic [7:0] value, input logic sof);
      logic [7:0] bw;
      if (sof) begin
         lane_cnt = 0;
         pix_idx  = 0;
         word_idx = 0;
      end
      bw = (value >= `THRESHOLD) ? 8'hff : 8'h00;
      ref_pix[pix_idx] = bw;
      pix_idx  = (pix_idx + 1) % FRAME_PIX;
      acc_word = {acc_word[`WORD_W-10:0], 1'b0, bw};
      lane_cnt++;
      if (lane_cnt == `PIX_PER_WORD) begin
         word_q.push_back(acc_word);
         addr_q.push_back(word_idx);
         pending_words++;
         word_idx = (word_idx + 1) % `FRAME_WORDS;
         lane_cnt = 0;
      end
   endtask

   // random pixels held while not ready with sof on the first one if asked
   task automatic drive_pixels(input int count, input logic sof_first);
      logic [7:0] value;
      logic [7:0] coin;
      for (int i = 0; i < count; i++) begin
         draw_bits(8, value);
         pix_data = value;
         pix_sof  = sof_first && (i == 0);
         draw_bits(1, coin);
         pix_valid = coin[0];
         while (!(pix_valid && pix_ready)) begin
            @(negedge clk);
            if (!pix_valid) begin
               draw_bits(1, coin);
               pix_valid = coin[0];
            end
         end
         record_pixel(value, sof_first && (i == 0));
         @(negedge clk);
      end
      pix_valid = 1'b0;
      pix_sof   = 1'b0;
   endtask

   ////////////////////
   // run sequence
   ////////////////////

   initial begin
      arst_n    = 1'b0;
      pix_valid = 1'b0;
      pix_data  = '0;
      pix_sof   = 1'b0;
      mem_rdata = '0;
      for (int i = 0; i < `FRAME_WORDS; i++) begin
         mem[i] = {4{1'b0, 6'(i) ^ 6'h2a, 2'(i + 1)}};
      end
      for (int i = 0; i < LAT; i++) begin
         rd_pipe[i] = '0;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      // first frame, then a quiet frame checked on the display
      drive_pixels(FRAME_PIX, 1'b1);
      wait (pending_words == 0);
      @(posedge clk);
      quiet_state = 1;
      wait (quiet_state == 3);
      // stray pixels leave the packer mid word and off address 0
      drive_pixels(LEAD_PIX, 1'b0);
      // second frame while the display keeps reading
      drive_pixels(FRAME_PIX, 1'b1);
      wait (pending_words == 0);
      @(negedge clk);
      $display("All tests passed");
      $finish;
   end

   ////////////////////
   // memory model and checks
   ////////////////////

   always @(negedge clk) begin : monitor
      logic [`WORD_W-1:0] exp_word;
      int                 exp_addr;
      logic               exp_read;
      cycle_cnt++;
      assert (cycle_cnt < CYCLE_LIMIT)
         else fail_text("run did not finish within the cycle limit");

      // single memory port
      assert (!(mem_rd && mem_we))
         else fail_text("memory read and write in the same cycle");
      if (mem_rd || mem_we) begin
         assert (mem_addr < `FRAME_WORDS)
            else fail_value("memory address range", `FRAME_WORDS - 1, mem_addr);
      end

      // stall only while a packed word waits
      if (!pix_ready) begin
         stall_run++;
         assert (pending_words > 0)
            else fail_text("pix_ready low with no completed word waiting");
         assert (stall_run <= 2) else fail_value("back-pressure length", 2, stall_run);
      end else begin
         stall_run = 0;
      end

      // writes arrive in order, packed and addressed as modelled
      if (mem_we) begin
         assert (pending_words > 0) else fail_text("memory write without a completed word");
         exp_word = word_q.pop_front();
         exp_addr = addr_q.pop_front();
         pending_words--;
         assert (mem_wdata.raw == exp_word) else fail_value("packing", exp_word, mem_wdata.raw);
         assert (mem_addr == exp_addr) else fail_value("addressing", exp_addr, mem_addr);
         mem[mem_addr] = mem_wdata.raw;
      end

      // read data returns LAT cycles after mem_rd
      mem_rdata.raw = rd_pipe[LAT-1];
      for (int k = LAT - 1; k > 0; k--) begin
         rd_pipe[k] = rd_pipe[k-1];
      end
      rd_pipe[0] = mem_rd ? mem[mem_addr] : '0;

      // a read lands on screen after its latency plus the unpack register
      exp_read = !video_blank && (col_cnt % `PIX_PER_WORD == 0);
      assert (rd_hist[LAT] == exp_read)
         else fail_text("memory read not aligned with a visible group of four pixels");
      rd_hist = {rd_hist[LAT-1:0], mem_rd};

      // sync periods
      if (video_hsync && !prev_hsync) begin
         if (last_hsync >= 0) begin
            assert (cycle_cnt - last_hsync == `H_TOTAL)
               else fail_value("hsync period", `H_TOTAL, cycle_cnt - last_hsync);
         end
         last_hsync = cycle_cnt;
      end
      if (video_vsync && !prev_vsync) begin
         if (last_vsync >= 0) begin
            assert (cycle_cnt - last_vsync == FRAME_CYCLES)
               else fail_value("vsync period", FRAME_CYCLES, cycle_cnt - last_vsync);
         end
         last_vsync = cycle_cnt;
         assert (row_cnt == `V_ACTIVE) else fail_value("visible lines", `V_ACTIVE, row_cnt);
         row_cnt = 0;
         // quiet frame runs from one vsync to the next
         if (quiet_state == 2) begin
            assert (pixels_checked == FRAME_PIX)
               else fail_value("display pixels checked", FRAME_PIX, pixels_checked);
            quiet_state = 3;
         end else if (quiet_state == 1) begin
            quiet_state = 2;
         end
      end

      // blanking, line length and contents
      if (video_blank) begin
         assert (video_pixel == '0) else fail_value("blanked pixel", 0, video_pixel);
         if (!prev_blank) begin
            assert (col_cnt == `H_ACTIVE)
               else fail_value("visible line length", `H_ACTIVE, col_cnt);
            row_cnt++;
         end
         col_cnt = 0;
      end else begin
         if (quiet_state == 2) begin
            assert (video_pixel == ref_pix[row_cnt * `H_ACTIVE + col_cnt])
               else fail_value("display contents", ref_pix[row_cnt * `H_ACTIVE + col_cnt],
                               video_pixel);
            pixels_checked++;
         end
         col_cnt++;
      end

      prev_hsync = video_hsync;
      prev_vsync = video_vsync;
      prev_blank = video_blank;
   end

endmodule

`default_nettype wire

// File: verilog/frame_store_top.sv
// frame store top level
// pixel capture and display scan sharing one external memory through the arbiter

`default_nettype none

module frame_store_top (
   input  wire                     clk,
   input  wire                     arst_n,
   // pixel stream in
   input  wire                     pix_valid,
   output logic                    pix_ready,
   input  wire video_pkg::pixel_t  pix_data,
   input  wire                     pix_sof,
   // video out
   output video_pkg::pixel_t       video_pixel,
   output logic                    video_blank,
   output logic                    video_hsync,
   output logic                    video_vsync,
   // external memory
   output mem_pkg::mem_addr_t      mem_addr,
   output logic                    mem_rd,
   output logic                    mem_we,
   output mem_pkg::mem_word_t      mem_wdata,
   input  wire mem_pkg::mem_word_t mem_rdata
);

   // read path, display to arbiter
   logic               rd_strobe;
   mem_pkg::mem_addr_t rd_addr;
   mem_pkg::mem_word_t rd_data;

   // write path, capture to arbiter
   wr_port_if wr_bus ();

   pixel_capture capture0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .pix_valid (pix_valid),
      .pix_ready (pix_ready),
      .pix_data  (pix_data),
      .pix_sof   (pix_sof),
      .wr        (wr_bus.source)
   );

   display_scan scan0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .rd_strobe   (rd_strobe),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .video_pixel (video_pixel),
      .video_blank (video_blank),
      .video_hsync (video_hsync),
      .video_vsync (video_vsync)
   );

   mem_arbiter arb0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd_strobe (rd_strobe),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .wr        (wr_bus.sink),
      .mem_addr  (mem_addr),
      .mem_rd    (mem_rd),
      .mem_we    (mem_we),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
// memory arbiter
// display reads win the port, capture writes take the remaining cycles

`default_nettype none

module mem_arbiter (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     rd_strobe,
   input  wire mem_pkg::mem_addr_t rd_addr,
   output mem_pkg::mem_word_t      rd_data,
   wr_port_if.sink                 wr,
   output mem_pkg::mem_addr_t      mem_addr,
   output logic                    mem_rd,
   output logic                    mem_we,
   output mem_pkg::mem_word_t      mem_wdata,
   input  wire mem_pkg::mem_word_t mem_rdata
);

   logic wr_grant;

   ////////////////////
   // port select
   ////////////////////

   // write only in a cycle without a read
   assign wr_grant    = wr.wr_valid && !rd_strobe;
   assign wr.wr_ready = wr_grant;

   assign mem_rd    = rd_strobe;
   assign mem_we    = wr_grant;
   assign mem_addr  = rd_strobe ? rd_addr : wr.wr_addr;

   // write data can sit on the bus during reads, mem_we qualifies it
   assign mem_wdata = wr.wr_data;

   ////////////////////
   // read return
   ////////////////////

   // latency is fixed, display side counts it
   assign rd_data = mem_rdata;

   // single port, one access per cycle
   port_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !(mem_rd && mem_we));

endmodule

`default_nettype wire

// File: verilog/display_scan.sv
// display scanner
// raster timing, one word fetch per four pixels, lane unpacking to grey video

`default_nettype none

`include "frame_macros.svh"

module display_scan (
   input  wire                    clk,
   input  wire                    arst_n,
   output logic                   rd_strobe,
   output mem_pkg::mem_addr_t     rd_addr,
   input  wire mem_pkg::mem_word_t rd_data,
   output video_pkg::pixel_t      video_pixel,
   output logic                   video_blank,
   output logic                   video_hsync,
   output logic                   video_vsync
);

   // strobe register, memory latency, unpack register
   localparam int FETCH_DLY      = `MEM_READ_LATENCY + 2;
   localparam int WORDS_PER_LINE = `H_ACTIVE / `PIX_PER_WORD;
   localparam int LANE_W         = $clog2(`PIX_PER_WORD);

   video_pkg::hcount_t           hcount;
   video_pkg::vcount_t           vcount;
   logic                         visible;
   logic                         fetch;
   mem_pkg::mem_addr_t           word_idx;
   logic [`MEM_READ_LATENCY-1:0] rd_pend;
   mem_pkg::mem_word_t           pix_word;
   logic [FETCH_DLY-1:0]         blank_pipe;
   logic [FETCH_DLY-1:0]         hsync_pipe;
   logic [FETCH_DLY-1:0]         vsync_pipe;

   ////////////////////
   // raster counters
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hcount <= '0;
         vcount <= '0;
      end else if (hcount == video_pkg::hcount_t'(`H_TOTAL - 1)) begin
         hcount <= '0;
         if (vcount == video_pkg::vcount_t'(`V_TOTAL - 1)) begin
            vcount <= '0;
         end else begin
            vcount <= vcount + 1'b1;
         end
      end else begin
         hcount <= hcount + 1'b1;
      end
   end

   assign visible = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);

   // first pixel of every visible group of four
   assign fetch = visible && (hcount[LANE_W-1:0] == '0);

   // row-major word index within the frame
   assign word_idx = mem_pkg::mem_addr_t'(vcount * WORDS_PER_LINE + hcount / `PIX_PER_WORD);

   ////////////////////
   // fetch and timing pipeline
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_strobe  <= 1'b0;
         rd_pend    <= '0;
         blank_pipe <= '1;
         hsync_pipe <= '0;
         vsync_pipe <= '0;
      end else begin
         rd_strobe  <= fetch;
         // tracks reads in flight, msb marks data on rd_data
         rd_pend    <= {rd_pend[`MEM_READ_LATENCY-2:0], rd_strobe};
         blank_pipe <= {blank_pipe[FETCH_DLY-2:0], !visible};
         hsync_pipe <= {hsync_pipe[FETCH_DLY-2:0],
                        (hcount >= `H_SYNC_START) && (hcount < `H_SYNC_END)};
         vsync_pipe <= {vsync_pipe[FETCH_DLY-2:0], vcount == `V_SYNC_LINE};
      end
   end

   always_ff @(posedge clk) begin
      rd_addr <= word_idx;
   end

   ////////////////////
   // unpacking
   ////////////////////

   // load on returning data, else move next lane up to lane0
   always_ff @(posedge clk) begin
      if (rd_pend[`MEM_READ_LATENCY-1]) begin
         pix_word <= rd_data;
      end else begin
         pix_word.lanes.lane0 <= pix_word.lanes.lane1;
         pix_word.lanes.lane1 <= pix_word.lanes.lane2;
         pix_word.lanes.lane2 <= pix_word.lanes.lane3;
         pix_word.lanes.lane3 <= '0;
      end
   end

   assign video_blank = blank_pipe[FETCH_DLY-1];
   assign video_hsync = hsync_pipe[FETCH_DLY-1];
   assign video_vsync = vsync_pipe[FETCH_DLY-1];

   // black outside the visible area
   assign video_pixel = video_blank ? '0 : pix_word.lanes.lane0.pix;

   // every fetch lands on a visible output pixel
   fetch_visible: assert property (@(posedge clk) disable iff (!arst_n)
      rd_strobe |-> ##(`MEM_READ_LATENCY + 1) !video_blank);

endmodule

`default_nettype wire

// File: verilog/pixel_capture.sv
// pixel capture
// thresholds incoming pixels, packs four per word and raises a sequential write

`default_nettype none

`include "frame_macros.svh"

module pixel_capture (
   input  wire                clk,
   input  wire                arst_n,
   input  wire                pix_valid,
   output logic               pix_ready,
   input  wire video_pkg::pixel_t pix_data,
   input  wire                pix_sof,
   wr_port_if.source          wr
);

   localparam int LANE_W = $clog2(`PIX_PER_WORD);
   localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`PIX_PER_WORD - 1);

   logic               accept;
   logic               word_done;
   logic               word_pend;
   logic [LANE_W-1:0]  lane_cnt;
   video_pkg::pixel_t  bw_pix;
   mem_pkg::mem_addr_t word_addr;
   mem_pkg::mem_word_t asm_word;

   ////////////////////
   // input handshake
   ////////////////////

   // stall only while a finished word waits for the port
   assign pix_ready = !word_pend;
   assign accept    = pix_valid && pix_ready;

   // black or white
   assign bw_pix = (pix_data >= `THRESHOLD) ? '1 : '0;

   // fourth lane filled, sof always opens a new word instead
   assign word_done = accept && !pix_sof && (lane_cnt == LAST_LANE);

   ////////////////////
   // lane packing
   ////////////////////

   // shift left by one lane, first pixel ends up in lane0
   always_ff @(posedge clk) begin
      if (accept) begin
         asm_word.lanes.lane0 <= asm_word.lanes.lane1;
         asm_word.lanes.lane1 <= asm_word.lanes.lane2;
         asm_word.lanes.lane2 <= asm_word.lanes.lane3;
         asm_word.lanes.lane3 <= '{pad: 1'b0, pix: bw_pix};
      end
   end

   ////////////////////
   // lane count, address, request
   ////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lane_cnt  <= '0;
         word_addr <= '0;
         word_pend <= 1'b0;
      end else begin
         if (accept) begin
            if (pix_sof) begin
               // sof pixel is lane 0 of word 0
               lane_cnt  <= LANE_W'(1);
               word_addr <= '0;
            end else begin
               lane_cnt <= lane_cnt + 1'b1;
            end
         end
         if (word_done) begin
            word_pend <= 1'b1;
         end else if (word_pend && wr.wr_ready) begin
            // word written, step to next frame address
            word_pend <= 1'b0;
            if (word_addr == mem_pkg::mem_addr_t'(`FRAME_WORDS - 1)) begin
               word_addr <= '0;
            end else begin
               word_addr <= word_addr + 1'b1;
            end
         end
      end
   end

   // packer holds still while pending, so it doubles as the payload
   assign wr.wr_valid = word_pend;
   assign wr.wr_addr  = word_addr;
   assign wr.wr_data  = asm_word;

   // a waiting write must not change under the arbiter
   wr_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
      wr.wr_valid && !wr.wr_ready |=>
         wr.wr_valid && $stable(wr.wr_addr) && $stable(wr.wr_data));

endmodule

`default_nettype wire

// File: verilog/wr_port_if.sv
// write request channel
// carries one packed word and its address from capture to the arbiter

`default_nettype none

interface wr_port_if;

   // handshake, transfer when both are high on a clock edge
   logic               wr_valid;
   logic               wr_ready;

   // payload, held stable while wr_valid waits
   mem_pkg::mem_addr_t wr_addr;
   mem_pkg::mem_word_t wr_data;

   // capture side
   modport source (output wr_valid, wr_addr, wr_data, input wr_ready);

   // arbiter side
   modport sink (input wr_valid, wr_addr, wr_data, output wr_ready);

endinterface

`default_nettype wire

// File: verilog/mem_pkg.sv
// frame buffer memory types
// word address and the two views of one 36-bit memory word

`default_nettype none

`include "frame_macros.svh"

package mem_pkg;

   // word address on the external port
   typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

   // one 9-bit lane, the spare top bit is always written 0
   typedef struct packed {
      logic               pad;
      video_pkg::pixel_t  pix;
   } mem_lane_t;

   // four lanes per word
   // lane0 sits in the top bits and is the leftmost pixel on screen
   typedef struct packed {
      mem_lane_t lane0;
      mem_lane_t lane1;
      mem_lane_t lane2;
      mem_lane_t lane3;
   } mem_lanes_t;

   // raw bus view for the port, lane view for packer and unpacker
   typedef union packed {
      logic [`WORD_W-1:0] raw;
      mem_lanes_t         lanes;
   } mem_word_t;

endpackage

`default_nettype wire

// File: verilog/video_pkg.sv
// video types
// grey pixel and raster position counters

`default_nettype none

`include "frame_macros.svh"

package video_pkg;

   ////////////////////
   // pixel
   ////////////////////

   // one grey sample, 0 is black
   typedef logic [`PIX_W-1:0] pixel_t;

   ////////////////////
   // raster position
   ////////////////////

   // sized for full xga, only the low bits move here
   typedef logic [10:0] hcount_t;

   // line number within the frame
   typedef logic [9:0] vcount_t;

endpackage

`default_nettype wire

// File: include/frame_macros.svh
// frame store parameters
// raster geometry, pixel threshold and external memory word layout

`ifndef FRAME_MACROS_SVH
`define FRAME_MACROS_SVH

// horizontal raster, in pixel clocks
`define H_ACTIVE 32
`define H_TOTAL 40
`define H_SYNC_START 34
`define H_SYNC_END 36

// vertical raster, in lines
`define V_ACTIVE 8
`define V_TOTAL 10
`define V_SYNC_LINE 8

// pixel and word packing
`define PIX_W 8
`define PIX_PER_WORD 4
`define WORD_W 36

// external synchronous memory
`define MEM_ADDR_W 19
`define FRAME_WORDS ((`H_ACTIVE * `V_ACTIVE) / `PIX_PER_WORD)
`define MEM_READ_LATENCY 2

// luminance cut for black/white decision
`define THRESHOLD 128

`endif
